// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = rename_tb
RTL_TOP  = rename_unit
FLIST    = rename_unit.f
LOG      = sim.log
FAIL_MSG = Test failed
PASS_MSG = Test completed successfully

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): $(FLIST) $(shell cat $(FLIST))
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@! grep -q "$(FAIL_MSG)" $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(TOOL) --lint-only -Wall --top-module $(RTL_TOP) -f $(FLIST)

clean:
	rm -rf obj_dir $(LOG)

// ==== hw/br_stack.sv ====
`default_nettype none

module br_stack #(
	parameter int BR_NUM = 4
) (
	input  wire                              clk,
	input  wire                              rst,
	input  wire                              alloc_i,
	input  wire                              res_vld_i,
	input  wire                              res_correct_i,
	input  wire [BR_NUM-1:0]                 res_bit_i,
	input  wire rename_pkg::cdb_t            cdb_i,
	input  wire rename_pkg::map_tbl_t        bak_mt_i,
	input  wire [rename_pkg::FL_PTR_W:0]     bak_fl_head_i,
	output logic                             full_o,
	output logic [BR_NUM-1:0]                alloc_bit_o,
	output logic                             recover_o,
	output rename_pkg::map_tbl_t             rc_mt_o,
	output logic [rename_pkg::FL_PTR_W:0]    rc_fl_head_o
);
	import rename_pkg::*;

	// Live checkpoint slots
	logic [BR_NUM-1:0]             mask_q;
	logic [BR_NUM-1:0]             mask_next;
	// Row j lists the slots already live when slot j was taken
	logic [BR_NUM-1:0][BR_NUM-1:0] older_q;
	// Slots younger than the resolving branch
	logic [BR_NUM-1:0]             kill;
	// Slots released this cycle
	logic [BR_NUM-1:0]             clr;
	// Mask once this cycle's release is applied
	logic [BR_NUM-1:0]             avail;

	// Per-slot recovery data
	map_tbl_t          ent_mt [BR_NUM];
	logic [FL_PTR_W:0] ent_head [BR_NUM];

	// A slot is younger if the resolving slot sits in its older set
	always_comb begin
		for (int j = 0; j < BR_NUM; j++) begin
			kill[j] = |(older_q[j] & res_bit_i);
		end
	end

	// CORRECT frees one slot, WRONG frees it and everything after it
	always_comb begin
		clr = '0;
		if (res_vld_i) begin
			clr = res_correct_i ? res_bit_i : (res_bit_i | kill);
		end
	end

	assign avail  = mask_q & ~clr;
	assign full_o = &avail;

	// Lowest clear bit, so a slot freed this cycle is reusable at once
	assign alloc_bit_o = ~avail & (avail + 1'b1);

	assign mask_next = alloc_i ? (avail | alloc_bit_o) : avail;

	always_ff @(posedge clk) begin
		if (rst) begin
			mask_q  <= '0;
			older_q <= '0;
		end else begin
			mask_q <= mask_next;
			for (int j = 0; j < BR_NUM; j++) begin
				if (alloc_i && alloc_bit_o[j]) begin
					// New branch is younger than every slot still live
					older_q[j] <= avail;
				end else begin
					// Released slots drop out of all age sets
					older_q[j] <= older_q[j] & ~clr;
				end
			end
		end
	end

	// Entries freeze on the live mask, released ones resume shadowing
	for (genvar i = 0; i < BR_NUM; i++) begin : g_ent
		br_stack_ent u_ent (
			.clk           (clk),
			.rst           (rst),
			.mask_bit_i    (avail[i]),
			.cdb_i         (cdb_i),
			.bak_mt_i      (bak_mt_i),
			.bak_fl_head_i (bak_fl_head_i),
			.rc_mt_o       (ent_mt[i]),
			.rc_fl_head_o  (ent_head[i])
		);
	end

	assign recover_o = res_vld_i && !res_correct_i;

	// One-hot select of the resolving slot's copy
	always_comb begin
		rc_mt_o      = '0;
		rc_fl_head_o = '0;
		for (int i = 0; i < BR_NUM; i++) begin
			if (res_bit_i[i]) begin
				rc_mt_o      = ent_mt[i];
				rc_fl_head_o = ent_head[i];
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/br_stack_ent.sv ====
`default_nettype none

module br_stack_ent (
	input  wire                              clk,
	input  wire                              rst,
	input  wire                              mask_bit_i,
	input  wire rename_pkg::cdb_t            cdb_i,
	input  wire rename_pkg::map_tbl_t        bak_mt_i,
	input  wire [rename_pkg::FL_PTR_W:0]     bak_fl_head_i,
	output rename_pkg::map_tbl_t             rc_mt_o,
	output logic [rename_pkg::FL_PTR_W:0]    rc_fl_head_o
);
	import rename_pkg::*;

	// Checkpointed map table and free-list head
	map_tbl_t          mt_q;
	logic [FL_PTR_W:0] head_q;

	always_ff @(posedge clk) begin
		if (rst || !mask_bit_i) begin
			// Slot idle, shadow the next-state rename view each cycle
			// The edge that sets the mask bit leaves the branch's own view here
			mt_q   <= bak_mt_i;
			head_q <= bak_fl_head_i;
		end else if (cdb_i.vld) begin
			// Frozen, only ready bits follow the CDB
			for (int i = 0; i < MT_NUM; i++) begin
				if (mt_q[i].tag == cdb_i.tag) begin
					mt_q[i].rdy <= 1'b1;
				end
			end
		end
	end

	// Stored copy always offered, the stack picks the slot
	assign rc_mt_o      = mt_q;
	assign rc_fl_head_o = head_q;

endmodule

`default_nettype wire

// ==== hw/free_list.sv ====
`default_nettype none

module free_list (
	input  wire                               clk,
	input  wire                               rst,
	input  wire                               pop_i,
	input  wire                               push_i,
	input  wire [rename_pkg::PRF_IDX_W-1:0]   push_tag_i,
	input  wire                               recover_i,
	input  wire [rename_pkg::FL_PTR_W:0]      rc_head_i,
	output logic [rename_pkg::PRF_IDX_W-1:0]  head_tag_o,
	output logic [rename_pkg::FL_PTR_W:0]     head_o,
	output logic                              empty_o
);
	import rename_pkg::*;

	// Tag storage, circular
	logic [PRF_IDX_W-1:0] fifo_q [FL_NUM];

	// Read and write pointers with wrap bit on top
	logic [FL_PTR_W:0] head_q;
	logic [FL_PTR_W:0] tail_q;
	logic [FL_PTR_W:0] head_next;

	// Equal pointers including wrap means nothing left to hand out
	assign empty_o = (head_q == tail_q);

	// Tag the next renamed destination receives
	assign head_tag_o = fifo_q[head_q[FL_PTR_W-1:0]];

	always_comb begin
		if (recover_i) begin
			// Rewind to the head saved right after the branch popped
			head_next = rc_head_i;
		end else if (pop_i) begin
			head_next = head_q + 1'b1;
		end else begin
			head_next = head_q;
		end
	end

	// Next-state head, so a checkpoint taken this edge includes the pop
	assign head_o = head_next;

	always_ff @(posedge clk) begin
		if (rst) begin
			head_q <= '0;
			// Full at reset, wrap bits differ and indices match
			tail_q <= {1'b1, {FL_PTR_W{1'b0}}};
		end else begin
			head_q <= head_next;
			// Tail never moves back, retired tags stay owned by the list
			if (push_i) begin
				tail_q <= tail_q + 1'b1;
			end
		end
	end

	// Loaded with the unmapped tags 32 to 63 in order
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < FL_NUM; i++) begin
				fifo_q[i] <= PRF_IDX_W'(MT_NUM + i);
			end
		end else if (push_i) begin
			fifo_q[tail_q[FL_PTR_W-1:0]] <= push_tag_i;
		end
	end

endmodule

`default_nettype wire

// ==== hw/map_table.sv ====
`default_nettype none

module map_table (
	input  wire                               clk,
	input  wire                               rst,
	input  wire rename_pkg::dispatch_t        disp_i,
	input  wire                               accept_i,
	input  wire [rename_pkg::PRF_IDX_W-1:0]   new_tag_i,
	input  wire rename_pkg::cdb_t             cdb_i,
	input  wire                               recover_i,
	input  wire rename_pkg::map_tbl_t         rc_mt_i,
	output rename_pkg::map_ent_t              src1_o,
	output rename_pkg::map_ent_t              src2_o,
	output logic [rename_pkg::PRF_IDX_W-1:0]  old_tag_o,
	output rename_pkg::map_tbl_t              mt_next_o
);
	import rename_pkg::*;

	// Current architectural to physical mapping
	map_tbl_t mt_q;

	// Mark an entry ready when the CDB carries its tag
	function automatic map_ent_t cdb_fwd(map_ent_t ent, cdb_t cdb);
		map_ent_t res;
		res = ent;
		if (cdb.vld && (cdb.tag == ent.tag)) begin
			res.rdy = 1'b1;
		end
		return res;
	endfunction

	// Sources read the table before this instruction's own write
	assign src1_o = cdb_fwd(mt_q[disp_i.arch_src1], cdb_i);
	assign src2_o = cdb_fwd(mt_q[disp_i.arch_src2], cdb_i);

	// Previous mapping of the destination, freed when this one retires
	assign old_tag_o = mt_q[disp_i.arch_dst].tag;

	always_comb begin
		// Recovery replaces the whole table
		mt_next_o = recover_i ? rc_mt_i : mt_q;

		// CDB of this cycle also lands on a restored table
		for (int i = 0; i < MT_NUM; i++) begin
			mt_next_o[i] = cdb_fwd(mt_next_o[i], cdb_i);
		end

		// New destination starts out waiting for its result
		if (accept_i && !recover_i) begin
			mt_next_o[disp_i.arch_dst].rdy = 1'b0;
			mt_next_o[disp_i.arch_dst].tag = new_tag_i;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			// Identity map, all values present
			for (int i = 0; i < MT_NUM; i++) begin
				mt_q[i].rdy <= 1'b1;
				mt_q[i].tag <= PRF_IDX_W'(i);
			end
		end else begin
			mt_q <= mt_next_o;
		end
	end

endmodule

`default_nettype wire

// ==== hw/rename_pkg.sv ====
`default_nettype none

package rename_pkg;

	// Architectural and physical register counts
	localparam int MT_NUM     = 32;
	localparam int PRF_NUM    = 64;
	localparam int PRF_IDX_W  = $clog2(PRF_NUM);
	localparam int ARCH_IDX_W = $clog2(MT_NUM);

	// Free list holds every physical register not mapped at reset
	localparam int FL_NUM   = PRF_NUM - MT_NUM;
	// Index width, pointers carry one more bit for wrap
	localparam int FL_PTR_W = $clog2(FL_NUM);

	// Room for the one-hot branch slot in a rename response
	// The stack depth of a given instance may not exceed this
	localparam int BR_MAX = 8;

	// One map-table word, ready flag on top
	typedef struct packed {
		logic                 rdy;
		logic [PRF_IDX_W-1:0] tag;
	} map_ent_t;

	// Whole map table, indexed by architectural register
	typedef map_ent_t [MT_NUM-1:0] map_tbl_t;

	// One instruction offered for rename
	typedef struct packed {
		logic                  vld;
		logic [ARCH_IDX_W-1:0] arch_dst;
		logic [ARCH_IDX_W-1:0] arch_src1;
		logic [ARCH_IDX_W-1:0] arch_src2;
		logic                  is_br;
	} dispatch_t;

	// Rename result, valid in the cycle of an accepted dispatch
	typedef struct packed {
		map_ent_t             src1;
		map_ent_t             src2;
		logic [PRF_IDX_W-1:0] dst_tag;
		logic [PRF_IDX_W-1:0] old_tag;
		// One-hot checkpoint slot, zero for non-branches
		logic [BR_MAX-1:0]    br_bit;
	} rename_rsp_t;

	// Common data bus broadcast of a completed tag
	typedef struct packed {
		logic                 vld;
		logic [PRF_IDX_W-1:0] tag;
	} cdb_t;

endpackage

`default_nettype wire

// ==== hw/rename_unit.sv ====
`default_nettype none

module rename_unit #(
	parameter int BR_NUM = 4
) (
	input  wire                               clk,
	input  wire                               rst,
	input  wire rename_pkg::dispatch_t        dispatch_i,
	input  wire rename_pkg::cdb_t             cdb_i,
	input  wire                               retire_vld_i,
	input  wire [rename_pkg::PRF_IDX_W-1:0]   retire_tag_i,
	input  wire                               br_res_vld_i,
	input  wire                               br_res_correct_i,
	input  wire [BR_NUM-1:0]                  br_res_bit_i,
	output rename_pkg::rename_rsp_t           rsp_o,
	output logic                              stall_o
);
	import rename_pkg::*;

	// Handshake and control
	logic accept;
	logic br_alloc;
	logic fl_empty;
	logic br_full;
	logic recover;

	// Rename data between the blocks
	logic [PRF_IDX_W-1:0] new_tag;
	logic [PRF_IDX_W-1:0] old_tag;
	logic [FL_PTR_W:0]    fl_head;
	logic [FL_PTR_W:0]    rc_fl_head;
	map_tbl_t             mt_next;
	map_tbl_t             rc_mt;
	map_ent_t             src1;
	map_ent_t             src2;
	logic [BR_NUM-1:0]    alloc_bit;

	// No tag, no checkpoint slot for a branch, or recovery under way
	assign stall_o = fl_empty || (dispatch_i.is_br && br_full) || recover;

	assign accept   = dispatch_i.vld && !stall_o;
	assign br_alloc = accept && dispatch_i.is_br;

	map_table u_map_table (
		.clk       (clk),
		.rst       (rst),
		.disp_i    (dispatch_i),
		.accept_i  (accept),
		.new_tag_i (new_tag),
		.cdb_i     (cdb_i),
		.recover_i (recover),
		.rc_mt_i   (rc_mt),
		.src1_o    (src1),
		.src2_o    (src2),
		.old_tag_o (old_tag),
		.mt_next_o (mt_next)
	);

	// Every accepted instruction takes a destination tag
	free_list u_free_list (
		.clk        (clk),
		.rst        (rst),
		.pop_i      (accept),
		.push_i     (retire_vld_i),
		.push_tag_i (retire_tag_i),
		.recover_i  (recover),
		.rc_head_i  (rc_fl_head),
		.head_tag_o (new_tag),
		.head_o     (fl_head),
		.empty_o    (fl_empty)
	);

	br_stack #(
		.BR_NUM (BR_NUM)
	) u_br_stack (
		.clk           (clk),
		.rst           (rst),
		.alloc_i       (br_alloc),
		.res_vld_i     (br_res_vld_i),
		.res_correct_i (br_res_correct_i),
		.res_bit_i     (br_res_bit_i),
		.cdb_i         (cdb_i),
		.bak_mt_i      (mt_next),
		.bak_fl_head_i (fl_head),
		.full_o        (br_full),
		.alloc_bit_o   (alloc_bit),
		.recover_o     (recover),
		.rc_mt_o       (rc_mt),
		.rc_fl_head_o  (rc_fl_head)
	);

	// Response assembled combinationally from this cycle's lookup
	always_comb begin
		rsp_o         = '0;
		rsp_o.src1    = src1;
		rsp_o.src2    = src2;
		rsp_o.dst_tag = new_tag;
		rsp_o.old_tag = old_tag;
		// Slot bit only reported for branches
		if (dispatch_i.is_br) begin
			rsp_o.br_bit = BR_MAX'(alloc_bit);
		end
	end

endmodule

`default_nettype wire

// ==== rename_unit.f ====
hw/rename_pkg.sv
hw/br_stack_ent.sv
hw/br_stack.sv
hw/map_table.sv
hw/free_list.sv
hw/rename_unit.sv
verif/rename_assert.sv
verif/rename_tb.sv

// ==== verif/rename_assert.sv ====
`default_nettype none

module rename_assert (
	input wire                          clk,
	input wire                          rst,
	input wire                          stall_i,
	input wire                          recover_i,
	input wire [rename_pkg::FL_PTR_W:0] head_i,
	input wire [rename_pkg::FL_PTR_W:0] rc_head_i
);

	// First cycle out of reset, free list full and no branch live
	a_stall_after_rst: assert property (
		@(posedge clk) $fell(rst) |-> !stall_i
	) else $error("stall_o high in the first cycle after reset");

	// A stalled request outside recovery takes no tag from the free list
	a_no_accept_on_stall: assert property (
		@(posedge clk) disable iff (rst) (stall_i && !recover_i) |-> $stable(head_i)
	) else $error("free-list head moved while stall_o is high");

	// Recovery lands on the saved head with no rename pop on top
	a_no_accept_on_recover: assert property (
		@(posedge clk) disable iff (rst) recover_i |-> (head_i == rc_head_i)
	) else $error("free-list head differs from the checkpoint during recovery");

endmodule

`default_nettype wire

// ==== verif/rename_tb.sv ====
`default_nettype none

module rename_tb;
	import rename_pkg::*;

	localparam int BR_NUM = 4;

	logic                 clk = 1'b0;
	logic                 rst;
	dispatch_t            disp;
	cdb_t                 cdb;
	logic                 retire_vld;
	logic [PRF_IDX_W-1:0] retire_tag;
	logic                 res_vld;
	logic                 res_ok;
	logic [BR_NUM-1:0]    res_bit;
	rename_rsp_t          rsp;
	logic                 stall;

	// Reference model, holds the DUT state after the last edge
	map_tbl_t             m_mt;
	logic [PRF_IDX_W-1:0] m_fifo [FL_NUM];
	logic [FL_PTR_W:0]    m_head;
	logic [FL_PTR_W:0]    m_tail;
	logic [BR_NUM-1:0]    m_mask;
	logic [BR_NUM-1:0]    m_older [BR_NUM];
	map_tbl_t             m_ck_mt [BR_NUM];
	logic [FL_PTR_W:0]    m_ck_head [BR_NUM];
	// ROB stand-in, old tags of live instructions in program order
	logic [PRF_IDX_W-1:0] q_old [$];
	// Queue length right after each branch, squash point
	int                   m_qlen [BR_NUM];

	int seed = 76022;
	int val_err = 0;
	int timeouts = 0;

	always #10 clk = ~clk;

	rename_unit #(
		.BR_NUM (BR_NUM)
	) DUT (
		.clk              (clk),
		.rst              (rst),
		.dispatch_i       (disp),
		.cdb_i            (cdb),
		.retire_vld_i     (retire_vld),
		.retire_tag_i     (retire_tag),
		.br_res_vld_i     (res_vld),
		.br_res_correct_i (res_ok),
		.br_res_bit_i     (res_bit),
		.rsp_o            (rsp),
		.stall_o          (stall)
	);

	bind rename_unit rename_assert u_assert (
		.clk       (clk),
		.rst       (rst),
		.stall_i   (stall_o),
		.recover_i (recover),
		.head_i    (fl_head),
		.rc_head_i (rc_fl_head)
	);

	// A broadcast tag makes a waiting entry ready
	function automatic map_ent_t ready_on_cdb(map_ent_t e, cdb_t c);
		if (c.vld && c.tag == e.tag) begin
			e.rdy = 1'b1;
		end
		return e;
	endfunction

	// Lowest zero bit as one-hot, zero when all set
	function automatic logic [BR_NUM-1:0] lowest_clear(logic [BR_NUM-1:0] v);
		logic [BR_NUM-1:0] r;
		r = '0;
		for (int i = BR_NUM - 1; i >= 0; i--) begin
			if (!v[i]) begin
				r = '0;
				r[i] = 1'b1;
			end
		end
		return r;
	endfunction

	function automatic int slot_of(logic [BR_NUM-1:0] v);
		int s;
		s = 0;
		for (int i = 0; i < BR_NUM; i++) begin
			if (v[i]) begin
				s = i;
			end
		end
		return s;
	endfunction

	// Slots freed by this cycle's resolve, WRONG takes the younger ones too
	function automatic logic [BR_NUM-1:0] released(logic vld, logic ok, logic [BR_NUM-1:0] b);
		logic [BR_NUM-1:0] r;
		r = '0;
		if (vld) begin
			r = b;
			for (int j = 0; j < BR_NUM; j++) begin
				if (!ok && |(m_older[j] & b)) begin
					r[j] = 1'b1;
				end
			end
		end
		return r;
	endfunction

	// Expected rename result, sources read before the own write
	function automatic rename_rsp_t ref_rename(dispatch_t d, cdb_t c, logic [BR_NUM-1:0] avail);
		rename_rsp_t r;
		r = '0;
		r.src1    = ready_on_cdb(m_mt[d.arch_src1], c);
		r.src2    = ready_on_cdb(m_mt[d.arch_src2], c);
		r.dst_tag = m_fifo[m_head[FL_PTR_W-1:0]];
		r.old_tag = m_mt[d.arch_dst].tag;
		if (d.is_br) begin
			r.br_bit = BR_MAX'(lowest_clear(avail));
		end
		return r;
	endfunction

	function automatic dispatch_t mk_disp(logic [ARCH_IDX_W-1:0] dst,
			logic [ARCH_IDX_W-1:0] s1, logic [ARCH_IDX_W-1:0] s2, logic br);
		dispatch_t d;
		d.vld       = 1'b1;
		d.arch_dst  = dst;
		d.arch_src1 = s1;
		d.arch_src2 = s2;
		d.is_br     = br;
		return d;
	endfunction

	// Reset view: identity map all ready, tags 32 to 63 free
	task automatic model_reset();
		for (int i = 0; i < MT_NUM; i++) begin
			m_mt[i].rdy = 1'b1;
			m_mt[i].tag = PRF_IDX_W'(i);
		end
		for (int i = 0; i < FL_NUM; i++) begin
			m_fifo[i] = PRF_IDX_W'(MT_NUM + i);
		end
		m_head = '0;
		m_tail = {1'b1, {FL_PTR_W{1'b0}}};
		m_mask = '0;
		for (int i = 0; i < BR_NUM; i++) begin
			m_older[i]   = '0;
			m_ck_mt[i]   = '0;
			m_ck_head[i] = '0;
			m_qlen[i]    = 0;
		end
	endtask

	// Apply one clock edge to the model
	task automatic advance_model(input logic acc, input logic [BR_NUM-1:0] avail);
		map_tbl_t          mt;
		logic [FL_PTR_W:0] head_n;
		logic [BR_NUM-1:0] clr;
		logic [BR_NUM-1:0] nb;
		logic              rec;
		int                s;
		clr = released(res_vld, res_ok, res_bit);
		s   = slot_of(res_bit);
		rec = res_vld && !res_ok;
		// Restore first, this cycle's CDB lands on top, then the new dst
		mt  = rec ? m_ck_mt[s] : m_mt;
		for (int i = 0; i < MT_NUM; i++) begin
			mt[i] = ready_on_cdb(mt[i], cdb);
		end
		head_n = rec ? m_ck_head[s] : m_head;
		if (acc) begin
			mt[disp.arch_dst].rdy = 1'b0;
			mt[disp.arch_dst].tag = m_fifo[m_head[FL_PTR_W-1:0]];
			head_n = head_n + 1'b1;
		end
		// Free slots shadow the next state, live ones only snoop the CDB
		for (int i = 0; i < BR_NUM; i++) begin
			if (!avail[i]) begin
				m_ck_mt[i]   = mt;
				m_ck_head[i] = head_n;
			end else begin
				for (int k = 0; k < MT_NUM; k++) begin
					m_ck_mt[i][k] = ready_on_cdb(m_ck_mt[i][k], cdb);
				end
			end
		end
		if (retire_vld) begin
			m_fifo[m_tail[FL_PTR_W-1:0]] = retire_tag;
			m_tail = m_tail + 1'b1;
			void'(q_old.pop_front());
		end
		// Squash everything dispatched after the mispredicted branch
		while (rec && q_old.size() > m_qlen[s]) begin
			void'(q_old.pop_back());
		end
		nb = (acc && disp.is_br) ? lowest_clear(avail) : '0;
		for (int j = 0; j < BR_NUM; j++) begin
			m_older[j] = nb[j] ? avail : (m_older[j] & ~clr);
		end
		m_mask = avail | nb;
		if (acc) begin
			q_old.push_back(m_mt[disp.arch_dst].tag);
		end
		for (int j = 0; j < BR_NUM; j++) begin
			if (nb[j]) begin
				m_qlen[j] = q_old.size();
			end
		end
		m_mt   = mt;
		m_head = head_n;
	endtask

	task automatic check_entry(input string name, input map_ent_t got, input map_ent_t exp);
		if (got !== exp) begin
			val_err++;
			$display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_rsp(input rename_rsp_t got, input rename_rsp_t exp);
		check_entry("rsp_o.src1", got.src1, exp.src1);
		check_entry("rsp_o.src2", got.src2, exp.src2);
		if ({got.dst_tag, got.old_tag, got.br_bit} !== {exp.dst_tag, exp.old_tag, exp.br_bit}) begin
			val_err++;
			$display("[FAIL] t=%0t rsp_o dst/old/br got %h/%h/%h expected %h/%h/%h", $time,
				got.dst_tag, got.old_tag, got.br_bit, exp.dst_tag, exp.old_tag, exp.br_bit);
		end
	endtask

	task automatic verify_stall(input logic got, input logic exp);
		if (got !== exp) begin
			val_err++;
			$display("[FAIL] t=%0t stall_o got %b expected %b", $time, got, exp);
		end
	endtask

	// Compare at mid-cycle, inputs and outputs settled
	always @(negedge clk) begin : compare
		logic [BR_NUM-1:0] avail;
		logic              exp_stall;
		logic              exp_acc;
		if (!rst) begin
			avail     = m_mask & ~released(res_vld, res_ok, res_bit);
			exp_stall = (m_head == m_tail) || (disp.is_br && &avail) || (res_vld && !res_ok);
			exp_acc   = disp.vld && !exp_stall;
			verify_stall(stall, exp_stall);
			if (exp_acc) begin
				check_rsp(rsp, ref_rename(disp, cdb, avail));
			end
			advance_model(exp_acc, avail);
		end
	end

	// One cycle of inputs, 1 unit after the rising edge
	task automatic drive(input dispatch_t d, input cdb_t c, input logic rv,
			input logic rsv, input logic rok, input logic [BR_NUM-1:0] rb);
		@(posedge clk);
		#1;
		disp       = d;
		cdb        = c;
		retire_vld = rv && (q_old.size() > 0);
		retire_tag = retire_vld ? q_old[0] : '0;
		res_vld    = rsv;
		res_ok     = rok;
		res_bit    = rb;
	endtask

	// Hold a request until the DUT takes it
	task automatic send(input dispatch_t d, input cdb_t c);
		int   n;
		logic acc;
		n   = 0;
		acc = 1'b0;
		while (!acc && n < 20) begin
			drive(d, c, 1'b0, 1'b0, 1'b0, '0);
			#5 acc = !stall;
			n++;
		end
		if (!acc) begin
			timeouts++;
			$display("Timeout: dispatch to r%0d was never accepted", d.arch_dst);
		end
	endtask

	initial begin : main
		dispatch_t         d;
		cdb_t              c;
		logic              rv;
		logic              rsv;
		logic              rok;
		logic              stalled;
		logic              pend;
		logic [BR_NUM-1:0] rb;
		int                n;
		int                k;
		rst        = 1'b1;
		disp       = '0;
		cdb        = '0;
		retire_vld = 1'b0;
		retire_tag = '0;
		res_vld    = 1'b0;
		res_ok     = 1'b0;
		res_bit    = '0;
		model_reset();
		repeat (5) @(posedge clk);
		#1 rst = 1'b0;

		// Identity map, then r1 waits on tag 32 until its broadcast
		send(mk_disp(5'd1, 5'd2, 5'd3, 1'b0), '0);
		send(mk_disp(5'd2, 5'd1, 5'd4, 1'b0), '0);
		c.vld = 1'b1;
		c.tag = 6'd32;
		send(mk_disp(5'd5, 5'd1, 5'd2, 1'b0), c);
		send(mk_disp(5'd6, 5'd1, 5'd0, 1'b0), '0);

		// Run the free list dry
		n       = 0;
		stalled = 1'b0;
		while (!stalled && n < 40) begin
			d = mk_disp(5'($random(seed)), 5'($random(seed)), 5'($random(seed)), 1'b0);
			drive(d, '0, 1'b0, 1'b0, 1'b0, '0);
			#5 stalled = stall;
			n++;
		end
		if (!stalled) begin
			timeouts++;
			$display("Timeout: free list never ran empty");
		end
		// Retired tags come back in FIFO order
		for (n = 0; n < 8; n++) begin
			drive('0, '0, 1'b1, 1'b0, 1'b0, '0);
		end
		for (n = 0; n < 8; n++) begin
			send(mk_disp(5'(n), 5'(n + 1), 5'(n + 2), 1'b0), '0);
		end
		n = 0;
		while (q_old.size() > 0 && n < 64) begin
			drive('0, '0, 1'b1, 1'b0, 1'b0, '0);
			n++;
		end

		// Fill every checkpoint slot
		for (k = 0; k < BR_NUM; k++) begin
			send(mk_disp(5'(k + 1), 5'(k), 5'(k + 2), 1'b0), '0);
			send(mk_disp(5'(k + 8), 5'(k + 1), 5'(k), 1'b1), '0);
		end
		// Branch held on a full stack, then slot 1 resolves CORRECT
		d = mk_disp(5'd12, 5'd1, 5'd2, 1'b1);
		drive(d, '0, 1'b0, 1'b0, 1'b0, '0);
		drive(d, '0, 1'b0, 1'b1, 1'b1, BR_NUM'(2));
		// r1 completes while slot 0 is frozen, then slot 0 is WRONG
		c.vld = 1'b1;
		c.tag = m_mt[1].tag;
		drive('0, c, 1'b0, 1'b0, 1'b0, '0);
		drive('0, '0, 1'b0, 1'b1, 1'b0, BR_NUM'(1));
		send(mk_disp(5'd20, 5'd1, 5'd8, 1'b0), '0);

		// Random mix, rejected requests are held
		pend = 1'b0;
		d    = '0;
		for (n = 0; n < 400; n++) begin
			// Model has taken the last edge, so the mask is the one the next inputs meet
			@(negedge clk);
			#1;
			if (!pend) begin
				d       = mk_disp(5'($random(seed)), 5'($random(seed)), 5'($random(seed)), 1'b0);
				d.vld   = 2'($random(seed)) != 2'd0;
				d.is_br = 2'($random(seed)) == 2'd0;
			end
			c.vld = 1'($random(seed));
			c.tag = 6'($random(seed));
			// Retire only when nothing is speculative
			rv  = (m_mask == '0) && 1'($random(seed));
			rsv = 1'b0;
			rok = 1'b0;
			rb  = '0;
			if (m_mask != '0 && 2'($random(seed)) == 2'd0) begin
				k   = int'($unsigned($random(seed)) % BR_NUM);
				rsv = 1'b1;
				rok = 1'($random(seed));
				for (int i = 0; i < BR_NUM; i++) begin
					if (rb == '0 && m_mask[(k + i) % BR_NUM]) begin
						rb[(k + i) % BR_NUM] = 1'b1;
					end
				end
			end
			drive(d, c, rv, rsv, rok, rb);
			#5 pend = d.vld && stall;
		end
		drive('0, '0, 1'b0, 1'b0, 1'b0, '0);
		drive('0, '0, 1'b0, 1'b0, 1'b0, '0);

		$display("Errors: %0d mismatches, %0d timeouts", val_err, timeouts);
		if (val_err == 0 && timeouts == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
